// ==== include/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address, physical
`define ICACHE_ADDR_W   32

// byte offset inside a 64-byte line
`define ICACHE_OFFSET_W 6

// set index, 64 sets
`define ICACHE_INDEX_W  6
`define ICACHE_SETS     64

// whatever is left above index and offset
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// one full line as memory returns it
`define ICACHE_LINE_W   512

// packet handed to the fetch stage
`define ICACHE_FETCH_W  64

`endif

// ==== logic/icache_pkg.sv ====
`include "icache_settings.svh"

package icache_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1, // store read done, compare tags
        MISS   = 2'd2, // line request out, waiting on memory
        REFILL = 2'd3
    } icache_state_e;

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;

endpackage

// ==== logic/icache_tagv_ram.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tagv_ram (
    input  logic               clk,
    input  logic               rstn,
    input  icache_pkg::index_t i_rindex,
    input  icache_pkg::index_t i_windex,
    input  logic [1:0]         i_we,
    input  icache_pkg::tag_t   i_wtag,
    output icache_pkg::tag_t   o_tag0,
    output icache_pkg::tag_t   o_tag1,
    output logic               o_valid0,
    output logic               o_valid1
);
    import icache_pkg::*;

    tag_t                    tag_mem [2][`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_q [2]; // flops, so reset can clear them
    tag_t                    tag_rd [2];
    logic [1:0]              valid_rd;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_we[w]) begin
                tag_mem[w][i_windex] <= i_wtag;
            end
            tag_rd[w] <= tag_mem[w][i_rindex];
        end
    end

    // valid bits, set on refill only
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
            end
            valid_rd <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_we[w]) begin
                    valid_q[w][i_windex] <= 1'b1;
                end
                valid_rd[w] <= valid_q[w][i_rindex];
            end
        end
    end

    assign o_tag0   = tag_rd[0];
    assign o_tag1   = tag_rd[1];
    assign o_valid0 = valid_rd[0];
    assign o_valid1 = valid_rd[1];

endmodule

// ==== logic/icache_data_ram.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_data_ram (
    input  logic               clk,
    input  icache_pkg::index_t i_rindex,
    input  icache_pkg::index_t i_windex,
    input  logic [1:0]         i_we,
    input  icache_pkg::line_t  i_wline,
    output icache_pkg::line_t  o_line0,
    output icache_pkg::line_t  o_line1
);
    import icache_pkg::*;

    // one block ram per way
    line_t line_mem [2][`ICACHE_SETS];
    line_t line_rd [2];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_we[w]) begin
                line_mem[w][i_windex] <= i_wline;
            end
            line_rd[w] <= line_mem[w][i_rindex]; // read gives old data on collision
        end
    end

    assign o_line0 = line_rd[0];
    assign o_line1 = line_rd[1];

endmodule

// ==== logic/icache_lru.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_lru (
    input  logic               clk,
    input  logic               rstn,
    input  icache_pkg::index_t i_index,
    input  logic               i_touch,
    input  logic               i_touch_way,
    output logic               o_victim
);

    // one bit per set, way used last
    logic [`ICACHE_SETS-1:0] mru_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru_q <= '0;
        end else if (i_touch) begin
            mru_q[i_index] <= i_touch_way;
        end
    end

    // two ways, so the victim is simply the other one
    assign o_victim = ~mru_q[i_index];

endmodule

// ==== logic/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       rstn,
    // fetch request
    input  logic                       i_req_valid,
    output logic                       o_req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  i_req_addr,
    // fetch response
    output logic                       o_resp_valid,
    output logic [`ICACHE_ADDR_W-1:0]  o_resp_pc,
    output logic [`ICACHE_FETCH_W-1:0] o_resp_data,
    // line request to memory
    output logic                       o_mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_addr,
    input  logic                       i_mem_ready,
    input  icache_pkg::line_t          i_mem_rdata,
    // stores
    output icache_pkg::index_t         o_rindex,
    output icache_pkg::index_t         o_windex,
    output logic [1:0]                 o_tagv_we,
    output logic [1:0]                 o_data_we,
    output icache_pkg::tag_t           o_wtag,
    output icache_pkg::line_t          o_wline,
    input  icache_pkg::tag_t           i_tag0,
    input  icache_pkg::tag_t           i_tag1,
    input  logic                       i_valid0,
    input  logic                       i_valid1,
    input  icache_pkg::line_t          i_line0,
    input  icache_pkg::line_t          i_line1,
    // lru
    output logic                       o_lru_touch,
    output logic                       o_lru_way,
    input  logic                       i_victim
);
    import icache_pkg::*;

    icache_state_e               state_q;
    icache_state_e               state_d;
    logic [`ICACHE_ADDR_W-1:0]   req_addr_q;   // request buffer
    line_t                       line_q;       // line buffer, filled from memory
    tag_t                        req_tag;
    logic                        hit0;
    logic                        hit1;
    logic                        cache_hit;
    logic                        hit_way;
    logic                        req_fire;
    logic                        mem_fire;
    logic                        in_lookup;
    logic                        in_refill;
    logic [1:0]                  refill_we;
    line_t                       rd_line;
    logic [`ICACHE_OFFSET_W-4:0] fetch_sel;    // 64-bit slot within the line

    assign in_lookup = (state_q == LOOKUP);
    assign in_refill = (state_q == REFILL);

    // tag compare against the buffered address
    assign req_tag   = req_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign hit0      = i_valid0 && (i_tag0 == req_tag);
    assign hit1      = i_valid1 && (i_tag1 == req_tag);
    assign cache_hit = hit0 || hit1;
    assign hit_way   = !hit0;   // way 0 wins a double match

    assign o_req_ready = (state_q == IDLE) || (in_lookup && cache_hit);
    assign req_fire    = i_req_valid && o_req_ready;
    assign mem_fire    = o_mem_req_valid && i_mem_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    state_d = MISS;
                end else if (!i_req_valid) begin
                    state_d = IDLE;
                end
            end
            MISS: begin
                if (i_mem_ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                state_d = IDLE; // next fetch goes through a fresh store read
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // payload buffers
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_addr_q <= i_req_addr;
        end
        if (mem_fire) begin
            line_q <= i_mem_rdata;
        end
    end

    // store read follows the incoming address every cycle
    assign o_rindex = i_req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign o_windex = req_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // refill goes to the lru victim
    assign refill_we = in_refill ? (i_victim ? 2'b10 : 2'b01) : 2'b00;
    assign o_tagv_we = refill_we;
    assign o_data_we = refill_we;
    assign o_wtag    = req_tag;
    assign o_wline   = line_q;

    assign o_lru_touch = (in_lookup && cache_hit) || in_refill;
    assign o_lru_way   = in_refill ? i_victim : hit_way;

    // response, from the hit way or from the line buffer
    assign fetch_sel    = req_addr_q[`ICACHE_OFFSET_W-1:3];
    assign rd_line      = in_refill ? line_q : (hit_way ? i_line1 : i_line0);
    assign o_resp_valid = (in_lookup && cache_hit) || in_refill;
    assign o_resp_pc    = req_addr_q;
    assign o_resp_data  = rd_line[fetch_sel*`ICACHE_FETCH_W +: `ICACHE_FETCH_W];

    assign o_mem_req_valid = (state_q == MISS);
    assign o_mem_addr      = {req_addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                              {`ICACHE_OFFSET_W{1'b0}}};  // line aligned

endmodule

// ==== logic/icache.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache (
    input  logic                       clk,
    input  logic                       rstn,
    // pipeline
    input  logic                       i_req_valid,
    output logic                       o_req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  i_req_addr,
    output logic                       o_resp_valid,
    output logic [`ICACHE_ADDR_W-1:0]  o_resp_pc,
    output logic [`ICACHE_FETCH_W-1:0] o_resp_data,
    // memory
    output logic                       o_mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_addr,
    input  logic                       i_mem_ready,
    input  icache_pkg::line_t          i_mem_rdata
);
    import icache_pkg::*;

    index_t     rindex;
    index_t     windex;
    logic [1:0] tagv_we;
    logic [1:0] data_we;
    tag_t       wtag;
    line_t      wline;
    tag_t       tag0;
    tag_t       tag1;
    logic       valid0;
    logic       valid1;
    line_t      line0;
    line_t      line1;
    logic       lru_touch;
    logic       lru_way;
    logic       victim;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_resp_valid    (o_resp_valid),
        .o_resp_pc       (o_resp_pc),
        .o_resp_data     (o_resp_data),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_addr      (o_mem_addr),
        .i_mem_ready     (i_mem_ready),
        .i_mem_rdata     (i_mem_rdata),
        .o_rindex        (rindex),
        .o_windex        (windex),
        .o_tagv_we       (tagv_we),
        .o_data_we       (data_we),
        .o_wtag          (wtag),
        .o_wline         (wline),
        .i_tag0          (tag0),
        .i_tag1          (tag1),
        .i_valid0        (valid0),
        .i_valid1        (valid1),
        .i_line0         (line0),
        .i_line1         (line1),
        .o_lru_touch     (lru_touch),
        .o_lru_way       (lru_way),
        .i_victim        (victim)
    );

    icache_tagv_ram u_tagv (
        .clk      (clk),
        .rstn     (rstn),
        .i_rindex (rindex),
        .i_windex (windex),
        .i_we     (tagv_we),
        .i_wtag   (wtag),
        .o_tag0   (tag0),
        .o_tag1   (tag1),
        .o_valid0 (valid0),
        .o_valid1 (valid1)
    );

    icache_data_ram u_data (
        .clk      (clk),
        .i_rindex (rindex),
        .i_windex (windex),
        .i_we     (data_we),
        .i_wline  (wline),
        .o_line0  (line0),
        .o_line1  (line1)
    );

    // lru looks at the buffered set, same as the write side
    icache_lru u_lru (
        .clk         (clk),
        .rstn        (rstn),
        .i_index     (windex),
        .i_touch     (lru_touch),
        .i_touch_way (lru_way),
        .o_victim    (victim)
    );

endmodule

// ==== verif/icache_chk.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_chk (
    input logic                      clk,
    input logic                      rstn,
    input logic                      i_mem_req_valid,
    input logic [`ICACHE_ADDR_W-1:0] i_mem_addr,
    input logic                      i_mem_ready,
    input logic                      i_resp_valid,
    input icache_pkg::icache_state_e i_state
);
    import icache_pkg::*;

    // line request holds until memory takes it
    property mem_req_held;
        @(posedge clk) disable iff (!rstn)
        (i_mem_req_valid && !i_mem_ready) |=> (i_mem_req_valid && $stable(i_mem_addr));
    endproperty

    property mem_addr_aligned;
        @(posedge clk) disable iff (!rstn)
        i_mem_req_valid |-> (i_mem_addr[`ICACHE_OFFSET_W-1:0] == '0);
    endproperty

    // no response while idle or waiting on memory
    property resp_state_ok;
        @(posedge clk) disable iff (!rstn)
        i_resp_valid |-> !((i_state == IDLE) || (i_state == MISS));
    endproperty

    a_mem_req_held:     assert property (mem_req_held)     else $error("mem request dropped or moved");
    a_mem_addr_aligned: assert property (mem_addr_aligned) else $error("mem address not line aligned");
    a_resp_state_ok:    assert property (resp_state_ok)    else $error("response in idle or miss");

endmodule

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int      NUM_REQ  = 400;
    localparam int      NUM_DIR  = 6;      // lru eviction sequence
    localparam int      NUM_STRM = 8;      // back-to-back hit stream
    localparam longint  TIMEOUT  = NUM_REQ * 20 * 40;
    localparam [31:0]   MEM_KEY  = 32'h5a5a_c3c3;
    localparam [5:0]    DIR_PAT  = 6'b101011; // miss pattern of the directed part in lsb-first order

    logic        clk;
    logic        rstn;
    logic        i_req_valid;
    logic [31:0] i_req_addr;
    logic        o_req_ready;
    logic        o_resp_valid;
    logic [31:0] o_resp_pc;
    logic [63:0] o_resp_data;
    logic        o_mem_req_valid;
    logic [31:0] o_mem_addr;
    logic        i_mem_ready;
    line_t       i_mem_rdata;

    integer      seed = 32'hdce5_8937;
    logic [31:0] req_list [NUM_REQ];
    int          next_idx;
    int          accepted;
    int          cycle;
    int          last_resp_cycle;
    int          stall_cnt;
    bit          front_xfer;   // oldest request already got its line
    logic [31:0] pc_q [$];
    bit          miss_q [$];
    bit          strm_q [$];
    int          err_pc;
    int          err_data;
    int          err_mem;
    int          err_other;

    // reference cache state
    tag_t   m_tag [2][`ICACHE_SETS];
    bit     m_valid [2][`ICACHE_SETS];
    bit     m_mru [`ICACHE_SETS];

    icache u_icache (
        .clk             (clk),
        .rstn            (rstn),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_resp_valid    (o_resp_valid),
        .o_resp_pc       (o_resp_pc),
        .o_resp_data     (o_resp_data),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_addr      (o_mem_addr),
        .i_mem_ready     (i_mem_ready),
        .i_mem_rdata     (i_mem_rdata)
    );

    bind icache_ctrl icache_chk u_chk (
        .clk             (clk),
        .rstn            (rstn),
        .i_mem_req_valid (o_mem_req_valid),
        .i_mem_addr      (o_mem_addr),
        .i_mem_ready     (i_mem_ready),
        .i_resp_valid    (o_resp_valid),
        .i_state         (state_q)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
        return word_addr ^ MEM_KEY;
    endfunction

    function automatic line_t mem_line(input logic [31:0] line_addr);
        line_t l;
        for (int i = 0; i < 16; i++) begin
            l[32*i +: 32] = mem_word((line_addr >> 2) + i);
        end
        return l;
    endfunction

    function automatic logic [63:0] exp_fetch(input logic [31:0] pc);
        logic [31:0] wa;
        wa = {2'b00, pc[31:3], 1'b0};
        return {mem_word(wa + 1), mem_word(wa)};
    endfunction

    // two-way lru model where a refill takes the way not used last
    task automatic model_access(input logic [31:0] addr, output bit miss);
        index_t idx;
        tag_t   tg;
        bit     way;
        idx  = addr[11:6];
        tg   = addr[31:12];
        miss = 1'b0;
        if (m_valid[0][idx] && m_tag[0][idx] == tg) begin
            way = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tg) begin
            way = 1'b1;
        end else begin
            miss = 1'b1;
            way  = ~m_mru[idx];
            m_tag[way][idx]   = tg;
            m_valid[way][idx] = 1'b1;
        end
        m_mru[idx] = way;
    endtask

    task automatic build_requests;
        tag_t   tags [3];
        index_t sets [4];
        int     r;
        tags = '{20'h00aa1, 20'h1b3c2, 20'h7f004};
        sets = '{6'd5, 6'd21, 6'd42, 6'd63};
        // A B A C A B in set 9
        req_list[0] = {tags[0], 6'd9, 6'h08};
        req_list[1] = {tags[1], 6'd9, 6'h10};
        req_list[2] = {tags[0], 6'd9, 6'h30};
        req_list[3] = {tags[2], 6'd9, 6'h00};
        req_list[4] = {tags[0], 6'd9, 6'h38};
        req_list[5] = {tags[1], 6'd9, 6'h20};
        for (int i = NUM_DIR; i < NUM_DIR + NUM_STRM; i++) begin
            req_list[i] = {tags[0], 6'd9, 6'h18};
        end
        for (int i = NUM_DIR + NUM_STRM; i < NUM_REQ; i++) begin
            r = $random(seed);
            req_list[i] = {tags[(r & 32'h7fff) % 3], sets[(r >> 16) & 3], r[29:24]};
        end
    endtask

    // request driver with response checks and memory responder
    always @(posedge clk) begin
        bit miss;
        if (rstn) begin
            cycle <= cycle + 1;
            if (i_req_valid && o_req_ready) begin
                model_access(i_req_addr, miss);
                if (accepted < NUM_DIR) begin
                    assert (miss == DIR_PAT[accepted]) else begin
                        $display("lru model gave the wrong hit/miss for directed request %0d",
                                 accepted);
                        err_other++;
                    end
                end
                pc_q.push_back(i_req_addr);
                miss_q.push_back(miss);
                strm_q.push_back(accepted > NUM_DIR && accepted < NUM_DIR + NUM_STRM);
                accepted++;
            end
            if (!i_req_valid || o_req_ready) begin
                if (next_idx < NUM_REQ &&
                    (next_idx < NUM_DIR + NUM_STRM || ($random(seed) & 7) != 0)) begin
                    i_req_valid <= 1'b1;
                    i_req_addr  <= req_list[next_idx];
                    next_idx++;
                end else begin
                    i_req_valid <= 1'b0;
                    i_req_addr  <= $random(seed);
                end
            end

            if (o_mem_req_valid && i_mem_ready) begin
                assert (pc_q.size() == 1 && miss_q[0] && !front_xfer) else begin
                    $display("memory transfer at %0t not expected by the model", $time);
                    err_mem++;
                end
                if (pc_q.size() > 0) begin
                    assert (o_mem_addr == {pc_q[0][31:6], 6'h00}) else begin
                        $display("ERR %0t o_mem_addr exp %h act %h", $time,
                                 {pc_q[0][31:6], 6'h00}, o_mem_addr);
                        err_mem++;
                    end
                end
                front_xfer  = 1'b1;
                i_mem_ready <= 1'b0;
                stall_cnt   <= ($random(seed) & 32'h7fff) % 6;
            end else if (o_mem_req_valid) begin
                if (stall_cnt == 0) begin
                    i_mem_ready <= 1'b1;
                    i_mem_rdata <= mem_line(o_mem_addr);
                end else begin
                    stall_cnt <= stall_cnt - 1;
                end
            end

            if (o_resp_valid) begin
                if (pc_q.size() == 0) begin
                    $display("response at %0t with no request outstanding", $time);
                    err_other++;
                end else begin
                    assert (o_resp_pc == pc_q[0]) else begin
                        $display("ERR %0t o_resp_pc exp %h act %h", $time, pc_q[0], o_resp_pc);
                        err_pc++;
                    end
                    assert (o_resp_data == exp_fetch(pc_q[0])) else begin
                        $display("ERR %0t o_resp_data exp %h act %h", $time,
                                 exp_fetch(pc_q[0]), o_resp_data);
                        err_data++;
                    end
                    assert (front_xfer == miss_q[0]) else begin
                        $display("ERR %0t mem_transfers exp %0d act %0d", $time,
                                 miss_q[0], front_xfer);
                        err_mem++;
                    end
                    if (strm_q[0]) begin
                        assert (cycle == last_resp_cycle + 1) else begin
                            $display("hit stream response at %0t not one cycle after the last",
                                     $time);
                            err_other++;
                        end
                    end
                    void'(pc_q.pop_front());
                    void'(miss_q.pop_front());
                    void'(strm_q.pop_front());
                    front_xfer = 1'b0;
                end
                last_resp_cycle <= cycle;
            end
        end
    end

    initial begin
        clk             = 1'b0;
        rstn            = 1'b0;
        i_req_valid     = 1'b0;
        i_req_addr      = '0;
        i_mem_ready     = 1'b0;
        i_mem_rdata     = '0;
        next_idx        = 0;
        accepted        = 0;
        cycle           = 0;
        last_resp_cycle = -10;
        stall_cnt       = 0;
        front_xfer      = 1'b0;
        err_pc          = 0;
        err_data        = 0;
        err_mem         = 0;
        err_other       = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_mru[s]      = 1'b0;
        end
        build_requests();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        #1;
        // idle outputs straight out of reset
        assert (!o_resp_valid && !o_mem_req_valid && o_req_ready) else begin
            $display("outputs after reset wrong: resp_valid %b mem_req_valid %b req_ready %b",
                     o_resp_valid, o_mem_req_valid, o_req_ready);
            err_other++;
        end
        while (!(accepted == NUM_REQ && pc_q.size() == 0)) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("errors: pc %0d data %0d mem %0d other %0d",
                 err_pc, err_data, err_mem, err_other);
        if (err_pc + err_data + err_mem + err_other == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout, %0d of %0d requests accepted", accepted, NUM_REQ);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== icache.f ====
+incdir+include
logic/icache_pkg.sv
logic/icache_tagv_ram.sv
logic/icache_data_ram.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache.sv
verif/icache_chk.sv
verif/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb \
    -f icache.f \
    -o icache_sim

# keep going after the run so the log can be searched
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run failed"
    exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
    echo "run ended without a result"
    exit 1
fi

exit 0
